// ==== all.f ====
hdl/lsu_pkg.sv
hdl/lsu_addr_ctl.sv
hdl/lsu_load_align.sv
hdl/lsu_stbuf.sv
hdl/lsu_top.sv
bench/lsu_dccm_model.sv
bench/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run of the LSU testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Pass only if the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

   localparam int LEN_RESET = 20;     // Cycles per test, rough upper figures
   localparam int LEN_LOAD  = 400;
   localparam int LEN_FWD   = 400;
   localparam int LEN_ERR   = 150;
   localparam int LEN_KILL  = 150;
   localparam int LEN_BP    = 1250;
   localparam int WATCHDOG_CYCLES =
      4 * (LEN_RESET + LEN_LOAD + LEN_FWD + LEN_ERR + LEN_KILL + LEN_BP);

   logic                clk = 1'b0;
   logic                rst, valid_d, load_d, store_d, unsign_d;
   logic                flush_r = 1'b0;       // Driven by the pipeline tracker
   lsu_pkg::lsu_size_t  size_d;
   lsu_pkg::word_t      rs1_d, rs2_d, dccm_rd_data;
   lsu_pkg::offset_t    offset_d;
   logic                result_valid_m, error_m, store_stall, idle, dccm_rden, dccm_wren;
   lsu_pkg::word_t      result_m, error_addr_m, dccm_wr_data;
   lsu_pkg::dccm_addr_t dccm_addr;
   lsu_pkg::byteen_t    dccm_wr_byteen;

   // Side copy of the instruction, D then M
   logic                kill_d, m_valid, m_load, m_store, m_uns, m_kill;
   lsu_pkg::word_t      tgt_addr, m_addr, m_data;
   lsu_pkg::lsu_size_t  m_size;

   logic [7:0]          shadow [lsu_pkg::DCCM_WORDS*4];   // Architectural bytes
   int                  n_checks, n_errors, stall_cycles;
   lsu_pkg::word_t      exp_val;
   logic                exp_err, st_err;

   lsu_top i_lsu_top (.*);

   lsu_dccm_model i_dccm (
      .clk       (clk),
      .rden      (dccm_rden),
      .wren      (dccm_wren),
      .addr      (dccm_addr),
      .wr_data   (dccm_wr_data),
      .wr_byteen (dccm_wr_byteen),
      .rd_data   (dccm_rd_data)
   );

   always #4 clk = ~clk;              // 8 ns period

   // **************************************************************************
   // Reference model
   // **************************************************************************

   function automatic int size_bytes(input lsu_pkg::lsu_size_t sz);
      case (sz)
         lsu_pkg::SIZE_BYTE: return 1;
         lsu_pkg::SIZE_HALF: return 2;
         default:            return 4;
      endcase
   endfunction

   // Expected load value from the shadow bytes, or the access error
   function automatic lsu_pkg::word_t ref_access(input lsu_pkg::word_t addr,
         input lsu_pkg::lsu_size_t sz, input logic uns, output logic err);
      lsu_pkg::word_t off, val;
      int             n;
      off = addr - lsu_pkg::DCCM_BASE;            // Below the base wraps high
      n   = size_bytes(sz);
      err = (off >= 32'(lsu_pkg::DCCM_WORDS * 4)) || ((addr[1:0] & 2'(n - 1)) != 2'b00);
      val = '0;
      if (!err) begin
         for (int i = 0; i < n; i++) begin
            val[8*i +: 8] = shadow[off + i];      // Little endian
         end
         if (!uns && (n < 4) && val[8*n-1]) begin
            val = val | (32'hFFFF_FFFF << (8*n)); // Sign fill
         end
      end
      return val;
   endfunction

   function automatic void write_shadow(input lsu_pkg::word_t addr,
         input lsu_pkg::lsu_size_t sz, input lsu_pkg::word_t data);
      lsu_pkg::word_t off;
      off = addr - lsu_pkg::DCCM_BASE;
      for (int i = 0; i < size_bytes(sz); i++) begin
         shadow[off + i] = data[8*i +: 8];        // Low bytes of rs2
      end
   endfunction

   // **************************************************************************
   // Pipeline tracker and compare
   // **************************************************************************

   // Sees the D inputs of the cycle that just ended
   always @(posedge clk) begin
      if (rst) begin
         m_valid <= 1'b0;
         flush_r <= 1'b0;
      end else begin
         m_valid <= valid_d;
         m_load  <= load_d;
         m_store <= store_d;
         m_size  <= size_d;
         m_uns   <= unsign_d;
         m_addr  <= tgt_addr;
         m_data  <= rs2_d;
         m_kill  <= kill_d;
         flush_r <= m_valid & m_kill;             // Kill lands while it sits in R
         // Store enters R now, visible to the load behind it
         if (m_valid && m_store && !m_kill) begin
            void'(ref_access(m_addr, m_size, 1'b1, st_err));
            if (!st_err) begin
               write_shadow(m_addr, m_size, m_data);
            end
         end
      end
   end

   task automatic check_value(input string name, input lsu_pkg::word_t got,
         input lsu_pkg::word_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERR %0t %s got %08h expected %08h", $time, name, got, exp);
      end
   endtask

   // M outputs are combinational and settled by the falling edge
   always @(negedge clk) begin
      if (!rst) begin
         if (m_valid) begin
            exp_val = ref_access(m_addr, m_size, m_uns, exp_err);
            check_value("error_m", 32'(error_m), 32'(exp_err));
            if (exp_err) begin
               check_value("error_addr_m", error_addr_m, m_addr);
               check_value("result_valid_m", 32'(result_valid_m), 32'd0);
            end else begin
               check_value("result_valid_m", 32'(result_valid_m), 32'(m_load));
               if (m_load) begin
                  check_value("result_m", result_m, exp_val);
               end
            end
         end else begin
            check_value("result_valid_m", 32'(result_valid_m), 32'd0);
            check_value("error_m", 32'(error_m), 32'd0);
         end
         check_value("dccm_rden_and_wren", 32'(dccm_rden & dccm_wren), 32'd0);
      end
   end

   // **************************************************************************
   // Stimulus
   // **************************************************************************

   // Random offset, base register picked so the sum hits addr
   task automatic issue(input logic ld, input logic st, input lsu_pkg::lsu_size_t sz,
         input logic uns, input lsu_pkg::word_t addr, input lsu_pkg::word_t data,
         input logic kill);
      lsu_pkg::offset_t off;
      off = lsu_pkg::offset_t'($urandom);
      @(posedge clk);
      while (st && store_stall) begin             // Hold the store back
         valid_d <= 1'b0;
         stall_cycles++;
         @(posedge clk);
      end
      valid_d  <= 1'b1;
      load_d   <= ld;
      store_d  <= st;
      size_d   <= sz;
      unsign_d <= uns;
      rs1_d    <= addr - {{20{off[11]}}, off};
      rs2_d    <= data;
      offset_d <= off;
      tgt_addr <= addr;
      kill_d   <= kill;
   endtask

   task automatic bubble(input int n);
      repeat (n) begin
         @(posedge clk);
         valid_d <= 1'b0;
      end
   endtask

   function automatic lsu_pkg::lsu_size_t rand_size();
      return lsu_pkg::lsu_size_t'($urandom_range(2, 0));
   endfunction

   function automatic lsu_pkg::word_t rand_addr(input lsu_pkg::lsu_size_t sz);
      lsu_pkg::word_t off;
      off = lsu_pkg::word_t'($urandom_range(lsu_pkg::DCCM_WORDS * 4 - 1, 0));
      return lsu_pkg::DCCM_BASE + (off & ~lsu_pkg::word_t'(size_bytes(sz) - 1));
   endfunction

   // Aligned access somewhere inside the word at w
   function automatic lsu_pkg::word_t addr_in_word(input lsu_pkg::word_t w,
         input lsu_pkg::lsu_size_t sz);
      lsu_pkg::word_t lane;
      lane = lsu_pkg::word_t'($urandom_range(3, 0)) & ~lsu_pkg::word_t'(size_bytes(sz) - 1);
      return {w[31:2], 2'b00} + lane;
   endfunction

   task automatic end_test(input string name, input int err_start);
      $display("test %-12s errors %0d stall cycles %0d", name, n_errors - err_start,
               stall_cycles);
   endtask

   // **************************************************************************
   // Tests
   // **************************************************************************

   task automatic test_loads();
      lsu_pkg::lsu_size_t sz;
      repeat (300) begin
         sz = rand_size();
         issue(1'b1, 1'b0, sz, 1'($urandom), rand_addr(sz), 32'd0, 1'b0);
         if ($urandom_range(3, 0) == 0) begin
            bubble(1);
         end
      end
   endtask

   // Two stores into one word, then loads right behind or a few cycles on
   task automatic test_forward();
      lsu_pkg::word_t     w;
      lsu_pkg::lsu_size_t sz;
      repeat (40) begin
         w = rand_addr(lsu_pkg::SIZE_WORD);
         repeat (2) begin
            sz = rand_size();
            issue(1'b0, 1'b1, sz, 1'b0, addr_in_word(w, sz), $urandom, 1'b0);
         end
         bubble($urandom_range(4, 0));
         issue(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, w, 32'd0, 1'b0);
         sz = rand_size();
         issue(1'b1, 1'b0, sz, 1'($urandom), addr_in_word(w, sz), 32'd0, 1'b0);
      end
   endtask

   task automatic test_errors();
      lsu_pkg::lsu_size_t sz;
      lsu_pkg::word_t     a;
      logic               st;
      repeat (60) begin
         sz = rand_size();
         st = 1'($urandom);
         case ($urandom_range(2, 0))
            0: a = lsu_pkg::DCCM_BASE - 4 * $urandom_range(64, 1);          // Below window
            1: a = lsu_pkg::DCCM_BASE + 4096 + 4 * $urandom_range(255, 0); // Above window
            default: begin
               a = rand_addr(lsu_pkg::SIZE_WORD);
               if (sz == lsu_pkg::SIZE_BYTE) begin
                  sz = lsu_pkg::SIZE_HALF;        // Bytes cannot misalign
               end
               if (sz == lsu_pkg::SIZE_HALF) begin
                  a = a + 1 + 2 * $urandom_range(1, 0);
               end else begin
                  a = a + $urandom_range(3, 1);
               end
            end
         endcase
         issue(~st, st, sz, 1'b0, a, $urandom, 1'b0);
         issue(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, {a[31:2], 2'b00}, 32'd0, 1'b0);
      end
   endtask

   task automatic test_kill();
      lsu_pkg::word_t     w;
      lsu_pkg::lsu_size_t sz;
      repeat (30) begin
         w = rand_addr(lsu_pkg::SIZE_WORD);
         issue(1'b0, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, w, $urandom, 1'($urandom));
         sz = rand_size();
         issue(1'b0, 1'b1, sz, 1'b0, addr_in_word(w, sz), $urandom, 1'b1);
         bubble($urandom_range(3, 0));
         issue(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, w, 32'd0, 1'b0);
      end
   endtask

   // Loads hog the port so the buffer only drains in store cycles
   task automatic test_backpressure();
      lsu_pkg::lsu_size_t sz;
      int                 wait_cycles;
      repeat (16) begin
         sz = rand_size();
         issue(1'b0, 1'b1, sz, 1'b0, rand_addr(sz), $urandom, 1'b0);
         repeat (3) begin
            sz = rand_size();
            issue(1'b1, 1'b0, sz, 1'($urandom), rand_addr(sz), 32'd0, 1'b0);
         end
      end
      repeat (60) begin
         issue(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, rand_addr(lsu_pkg::SIZE_WORD),
               32'd0, 1'b0);
      end
      bubble(1);
      wait_cycles = 0;
      @(posedge clk);
      while (!idle && (wait_cycles < 64)) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (!idle) begin
         n_errors++;
         $display("Store buffer did not drain, idle still low after %0d cycles", wait_cycles);
      end
      // Full readback against the shadow
      for (int i = 0; i < lsu_pkg::DCCM_WORDS; i++) begin
         issue(1'b1, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, lsu_pkg::DCCM_BASE + 4 * i, 32'd0, 1'b0);
      end
   endtask

   // **************************************************************************
   // Main sequence
   // **************************************************************************

   initial begin
      int             err_start;
      lsu_pkg::word_t fill;
      void'($urandom(32'h432e7317));
      rst          = 1'b1;
      valid_d      = 1'b0;
      load_d       = 1'b0;
      store_d      = 1'b0;
      size_d       = lsu_pkg::SIZE_WORD;
      unsign_d     = 1'b0;
      rs1_d        = '0;
      rs2_d        = '0;
      offset_d     = '0;
      kill_d       = 1'b0;
      tgt_addr     = '0;
      n_checks     = 0;
      n_errors     = 0;
      stall_cycles = 0;
      for (int w = 0; w < lsu_pkg::DCCM_WORDS; w++) begin
         fill = $urandom;                          // Same word into DCCM and shadow
         i_dccm.mem[w] = fill;
         for (int b = 0; b < 4; b++) begin
            shadow[4*w + b] = fill[8*b +: 8];
         end
      end
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      err_start = n_errors;
      @(negedge clk);
      check_value("idle", 32'(idle), 32'd1);
      check_value("dccm_wren", 32'(dccm_wren), 32'd0);
      check_value("dccm_rden", 32'(dccm_rden), 32'd0);
      check_value("store_stall", 32'(store_stall), 32'd0);
      end_test("reset", err_start);

      err_start = n_errors;
      test_loads();
      bubble(4);
      end_test("loads", err_start);

      err_start = n_errors;
      test_forward();
      bubble(4);
      end_test("forward", err_start);

      err_start = n_errors;
      test_errors();
      bubble(4);
      end_test("errors", err_start);

      err_start = n_errors;
      test_kill();
      bubble(4);
      end_test("kill", err_start);

      err_start = n_errors;
      test_backpressure();
      bubble(4);
      end_test("backpressure", err_start);

      $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Watchdog sized from the test lengths
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== bench/lsu_dccm_model.sv ====
`timescale 1ns/1ps

module lsu_dccm_model (
   input  logic                clk,
   input  logic                rden,           // Read issued this cycle
   input  logic                wren,           // Write lands at the closing edge
   input  lsu_pkg::dccm_addr_t addr,           // Shared read and write index
   input  lsu_pkg::word_t      wr_data,
   input  lsu_pkg::byteen_t    wr_byteen,
   output lsu_pkg::word_t      rd_data         // Valid the cycle after rden
);

   // **************************************************************************
   // Storage
   // **************************************************************************

   // Preloaded from the testbench at time zero
   lsu_pkg::word_t mem [lsu_pkg::DCCM_WORDS];

   // **************************************************************************
   // Single port access
   // **************************************************************************

   always @(posedge clk) begin
      if (rden) begin
         rd_data <= mem[addr];                 // One cycle read latency
      end
      if (wren) begin
         // Only the enabled lanes change
         for (int b = 0; b < 4; b++) begin
            if (wr_byteen[b]) begin
               mem[addr][8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
      end
   end

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                valid_d,
   input  logic                load_d,
   input  logic                store_d,
   input  lsu_pkg::lsu_size_t  size_d,
   input  logic                unsign_d,
   input  lsu_pkg::word_t      rs1_d,
   input  lsu_pkg::word_t      rs2_d,
   input  lsu_pkg::offset_t    offset_d,
   input  logic                flush_r,
   input  lsu_pkg::word_t      dccm_rd_data,
   output logic                result_valid_m,
   output lsu_pkg::word_t      result_m,
   output logic                error_m,
   output lsu_pkg::word_t      error_addr_m,
   output logic                store_stall,
   output logic                idle,
   output logic                dccm_rden,
   output logic                dccm_wren,
   output lsu_pkg::dccm_addr_t dccm_addr,
   output lsu_pkg::word_t      dccm_wr_data,
   output lsu_pkg::byteen_t    dccm_wr_byteen
);

   logic                rd_req_d, ld_valid_m, unsign_m, busy_mr;
   lsu_pkg::dccm_addr_t rd_addr_d, ld_addr_m, st_addr_r, drain_addr;
   lsu_pkg::lsu_size_t  size_m;
   logic [1:0]          byte_off_m;
   logic                st_commit_r, drain_valid, stbuf_empty;
   lsu_pkg::word_t      st_data_r, fwd_data_m, drain_data;
   lsu_pkg::byteen_t    st_byteen_r, fwd_byteen_m, drain_byteen;

   lsu_addr_ctl i_addr_ctl (.*);
   lsu_load_align i_load_align (.*);
   lsu_stbuf i_stbuf (.*);

   // **************************************************************************
   // DCCM port
   // **************************************************************************

   // Loads own the port, drain takes the idle cycles
   assign dccm_rden      = rd_req_d;
   assign dccm_wren      = drain_valid;               // Drain already yields to reads
   assign dccm_addr      = rd_req_d ? rd_addr_d : drain_addr;
   assign dccm_wr_data   = drain_data;
   assign dccm_wr_byteen = drain_byteen;

   // Nothing in flight and nothing left to write
   assign idle = ~busy_mr & stbuf_empty;

endmodule

// ==== hdl/lsu_stbuf.sv ====
`timescale 1ns/1ps

module lsu_stbuf (
   input  logic                clk,
   input  logic                rst,
   input  logic                st_commit_r,    // Store in R enters the queue
   input  lsu_pkg::dccm_addr_t st_addr_r,
   input  lsu_pkg::word_t      st_data_r,
   input  lsu_pkg::byteen_t    st_byteen_r,
   input  logic                rd_req_d,       // Port busy with a load read
   input  lsu_pkg::dccm_addr_t ld_addr_m,      // Load in M looking for data
   output lsu_pkg::word_t      fwd_data_m,
   output lsu_pkg::byteen_t    fwd_byteen_m,
   output logic                drain_valid,    // Write oldest entry this cycle
   output lsu_pkg::dccm_addr_t drain_addr,
   output lsu_pkg::word_t      drain_data,
   output lsu_pkg::byteen_t    drain_byteen,
   output logic                store_stall,
   output logic                stbuf_empty
);

   // Entry storage, no reset since count guards every read
   lsu_pkg::dccm_addr_t ent_addr   [lsu_pkg::STBUF_DEPTH];
   lsu_pkg::word_t      ent_data   [lsu_pkg::STBUF_DEPTH];
   lsu_pkg::byteen_t    ent_byteen [lsu_pkg::STBUF_DEPTH];

   logic [lsu_pkg::STBUF_PTR_BITS-1:0] rd_ptr;      // Oldest entry
   logic [lsu_pkg::STBUF_PTR_BITS-1:0] wr_ptr;      // Next free slot
   logic [lsu_pkg::STBUF_PTR_BITS:0]   count;       // One extra bit for full
   logic [lsu_pkg::STBUF_PTR_BITS:0]   free_cnt;

   // **************************************************************************
   // Queue control
   // **************************************************************************

   assign stbuf_empty = (count == '0);
   assign free_cnt    = (lsu_pkg::STBUF_PTR_BITS+1)'(lsu_pkg::STBUF_DEPTH) - count;
   assign store_stall = free_cnt < lsu_pkg::STALL_MARGIN;   // Room for D, M and R

   // Single port, so drain only when no load is reading
   assign drain_valid  = ~stbuf_empty & ~rd_req_d;
   assign drain_addr   = ent_addr[rd_ptr];
   assign drain_data   = ent_data[rd_ptr];
   assign drain_byteen = ent_byteen[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (st_commit_r) begin
            wr_ptr <= wr_ptr + 1'b1;     // Wraps at depth
         end
         if (drain_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({st_commit_r, drain_valid})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;     // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (st_commit_r) begin
         ent_addr[wr_ptr]   <= st_addr_r;
         ent_data[wr_ptr]   <= st_data_r;
         ent_byteen[wr_ptr] <= st_byteen_r;
      end
   end

   // **************************************************************************
   // Forwarding
   // **************************************************************************

   // Oldest first, then the R store, so later writes overwrite earlier
   // ones lane by lane. An entry drained last cycle is already in the
   // array, and a drain never overlaps a load read, so nothing is lost.
   always_comb begin
      logic [lsu_pkg::STBUF_PTR_BITS-1:0] idx;
      fwd_data_m   = '0;
      fwd_byteen_m = '0;
      for (int i = 0; i < lsu_pkg::STBUF_DEPTH; i++) begin
         idx = rd_ptr + lsu_pkg::STBUF_PTR_BITS'(i);
         if ((i < count) && (ent_addr[idx] == ld_addr_m)) begin
            for (int b = 0; b < 4; b++) begin
               if (ent_byteen[idx][b]) begin
                  fwd_data_m[8*b +: 8] = ent_data[idx][8*b +: 8];
                  fwd_byteen_m[b]      = 1'b1;
               end
            end
         end
      end
      // Store in R is newer than anything queued
      if (st_commit_r && (st_addr_r == ld_addr_m)) begin
         for (int b = 0; b < 4; b++) begin
            if (st_byteen_r[b]) begin
               fwd_data_m[8*b +: 8] = st_data_r[8*b +: 8];
               fwd_byteen_m[b]      = 1'b1;
            end
         end
      end
   end

endmodule

// ==== hdl/lsu_load_align.sv ====
`timescale 1ns/1ps

module lsu_load_align (
   input  logic               ld_valid_m,      // Good load in M
   input  lsu_pkg::lsu_size_t size_m,
   input  logic               unsign_m,        // Zero rather than sign extend
   input  logic [1:0]         byte_off_m,      // Byte offset within the word
   input  lsu_pkg::word_t     dccm_rd_data,    // Read issued from D last cycle
   input  lsu_pkg::word_t     fwd_data_m,      // Newest pending store bytes
   input  lsu_pkg::byteen_t   fwd_byteen_m,    // Lanes that fwd_data_m covers
   output logic               result_valid_m,
   output lsu_pkg::word_t     result_m
);

   lsu_pkg::word_t merged;    // Memory word with pending stores applied
   lsu_pkg::word_t shifted;   // Addressed bytes moved to the bottom
   logic           sign_b;    // Fill bit for a byte load
   logic           sign_h;    // Fill bit for a half load

   // **************************************************************************
   // Byte merge
   // **************************************************************************

   // Stores still in R or in the buffer are newer than the array contents
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         if (fwd_byteen_m[b]) begin
            merged[8*b +: 8] = fwd_data_m[8*b +: 8];
         end else begin
            merged[8*b +: 8] = dccm_rd_data[8*b +: 8];
         end
      end
   end

   // **************************************************************************
   // Extraction and extension
   // **************************************************************************

   assign shifted = merged >> {byte_off_m, 3'b000};

   // Alignment is already checked, so a half never crosses the word
   assign sign_b = ~unsign_m & shifted[7];
   assign sign_h = ~unsign_m & shifted[15];

   always_comb begin
      case (size_m)
         lsu_pkg::SIZE_BYTE: begin
            result_m = {{24{sign_b}}, shifted[7:0]};
         end
         lsu_pkg::SIZE_HALF: begin
            result_m = {{16{sign_h}}, shifted[15:0]};
         end
         default: begin
            result_m = shifted;        // Word, offset is zero here
         end
      endcase
   end

   // Result is only meaningful for a load that passed the checks;
   // faulting accesses report through error_m instead
   assign result_valid_m = ld_valid_m;

endmodule

// ==== hdl/lsu_addr_ctl.sv ====
`timescale 1ns/1ps

module lsu_addr_ctl (
   input  logic                clk,
   input  logic                rst,
   input  logic                valid_d,        // Instruction in D is a memory op
   input  logic                load_d,
   input  logic                store_d,
   input  lsu_pkg::lsu_size_t  size_d,
   input  logic                unsign_d,       // Zero extend the load result
   input  lsu_pkg::word_t      rs1_d,          // Base register
   input  lsu_pkg::word_t      rs2_d,          // Store data
   input  lsu_pkg::offset_t    offset_d,
   input  logic                flush_r,        // Kill the R instruction
   output logic                rd_req_d,       // Load reads the DCCM this cycle
   output lsu_pkg::dccm_addr_t rd_addr_d,
   output logic                ld_valid_m,     // Good load in M
   output lsu_pkg::lsu_size_t  size_m,
   output logic                unsign_m,
   output logic [1:0]          byte_off_m,
   output lsu_pkg::dccm_addr_t ld_addr_m,      // Word index for forwarding
   output logic                error_m,
   output lsu_pkg::word_t      error_addr_m,
   output logic                st_commit_r,    // R store goes to the buffer
   output lsu_pkg::dccm_addr_t st_addr_r,
   output lsu_pkg::word_t      st_data_r,      // Already in its byte lanes
   output lsu_pkg::byteen_t    st_byteen_r,
   output logic                busy_mr         // M or R holds an instruction
);

   lsu_pkg::word_t   addr_d, win_off_d;
   lsu_pkg::word_t   st_data_d;
   lsu_pkg::byteen_t byteen_d;
   logic             in_dccm_d, misalign_d, err_d;

   logic             valid_m, load_m, store_m, err_m;
   lsu_pkg::word_t   addr_m, st_data_m;
   lsu_pkg::byteen_t byteen_m;
   logic             valid_r, st_ok_r;

   // **************************************************************************
   // D stage
   // **************************************************************************

   assign addr_d    = rs1_d + {{20{offset_d[11]}}, offset_d};  // Sign-extended offset
   assign win_off_d = addr_d - lsu_pkg::DCCM_BASE;              // Wraps below the base
   assign in_dccm_d = win_off_d < lsu_pkg::word_t'(lsu_pkg::DCCM_WORDS * 4);

   // Misaligned accesses are not split, they fault
   assign misalign_d = ((size_d == lsu_pkg::SIZE_HALF) & addr_d[0]) |
                       ((size_d == lsu_pkg::SIZE_WORD) & (|addr_d[1:0]));

   assign err_d = valid_d & (load_d | store_d) & (~in_dccm_d | misalign_d);

   assign rd_req_d  = valid_d & load_d & ~err_d;  // Faulting load leaves memory alone
   assign rd_addr_d = addr_d[lsu_pkg::DCCM_ADDR_BITS+1:2];

   // Byte lanes of the store, moved to the addressed position
   always_comb begin
      case (size_d)
         lsu_pkg::SIZE_BYTE: byteen_d = 4'b0001;
         lsu_pkg::SIZE_HALF: byteen_d = 4'b0011;
         default:            byteen_d = 4'b1111;
      endcase
      byteen_d  = byteen_d << addr_d[1:0];
      st_data_d = rs2_d << {addr_d[1:0], 3'b000};
   end

   // **************************************************************************
   // M and R registers
   // **************************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_m <= 1'b0;
         load_m  <= 1'b0;
         store_m <= 1'b0;
         err_m   <= 1'b0;
         valid_r <= 1'b0;
         st_ok_r <= 1'b0;
      end else begin
         valid_m <= valid_d & (load_d | store_d);
         load_m  <= load_d;
         store_m <= store_d;
         err_m   <= err_d;
         valid_r <= valid_m;
         st_ok_r <= valid_m & store_m & ~err_m;  // Only clean stores may commit
      end
   end

   // Payload follows the packet
   always_ff @(posedge clk) begin
      size_m      <= size_d;
      unsign_m    <= unsign_d;
      addr_m      <= addr_d;
      st_data_m   <= st_data_d;
      byteen_m    <= byteen_d;
      st_addr_r   <= addr_m[lsu_pkg::DCCM_ADDR_BITS+1:2];
      st_data_r   <= st_data_m;
      st_byteen_r <= byteen_m;
   end

   assign ld_valid_m   = valid_m & load_m & ~err_m;
   assign byte_off_m   = addr_m[1:0];
   assign ld_addr_m    = addr_m[lsu_pkg::DCCM_ADDR_BITS+1:2];
   assign error_m      = valid_m & err_m;
   assign error_addr_m = addr_m;                    // Full computed address

   assign st_commit_r = st_ok_r & ~flush_r;         // Kill only hits R
   assign busy_mr     = valid_m | valid_r;

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

   // **************************************************************************
   // Widths
   // **************************************************************************

   typedef logic [31:0] word_t;          // Data or address word
   typedef logic [11:0] offset_t;        // Signed immediate from the decoder
   typedef logic [3:0]  byteen_t;        // One enable per byte lane

   // Access size from the decoder
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } lsu_size_t;

   // **************************************************************************
   // DCCM geometry
   // **************************************************************************

   localparam logic [31:0] DCCM_BASE = 32'hF004_0000;  // First byte of the window
   localparam int DCCM_WORDS         = 1024;           // 4 KB of 32-bit words
   localparam int DCCM_ADDR_BITS     = 10;             // log2 of DCCM_WORDS

   // Word index inside the memory
   typedef logic [DCCM_ADDR_BITS-1:0] dccm_addr_t;

   // **************************************************************************
   // Store buffer
   // **************************************************************************

   localparam int STBUF_DEPTH    = 8;     // Entries, power of two so pointers wrap
   localparam int STBUF_PTR_BITS = 3;     // log2 of STBUF_DEPTH

   // Free entries held back for the stores that may already sit in D, M and R
   // when the stall is raised. The decoder sees the stall one cycle too late
   // for the store in D, so all three pipeline slots need room.
   localparam int STALL_MARGIN   = 3;

endpackage
